// ==== common/mipsPkg.sv ====
// MIPS core shared definitions
package mipsPkg;

	localparam int WORD_W     = 32; // data and address width
	localparam int REG_ADDR_W = 5;
	localparam int REG_COUNT  = 32;
	localparam logic [REG_ADDR_W-1:0] RA_REG = 5'd31; // link register for jal

	// primary opcodes kept in this core
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opJ     = 6'h02,
		opJal   = 6'h03,
		opBeq   = 6'h04,
		opBne   = 6'h05,
		opAddi  = 6'h08,
		opSlti  = 6'h0a,
		opAndi  = 6'h0c,
		opOri   = 6'h0d,
		opLui   = 6'h0f,
		opLb    = 6'h20,
		opLh    = 6'h21,
		opLw    = 6'h23,
		opLbu   = 6'h24,
		opLhu   = 6'h25,
		opSb    = 6'h28,
		opSh    = 6'h29,
		opSw    = 6'h2b
	} opcode_t;

	typedef enum logic [5:0] {
		fnSll = 6'h00,
		fnSrl = 6'h02,
		fnJr  = 6'h08,
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnSlt = 6'h2a
	} funct_t;

	// multicycle sequence, fetch is the reset state
	typedef enum logic [3:0] {
		stFetch, stDecode, stMemAddr, stMemRead, stMemWriteBack, stMemWrite,
		stRExec, stRWriteBack, stIExec, stIWriteBack, stBranch, stJump,
		stJumpReg, stJal
	} ctrlState_t;

	typedef enum logic [1:0] {clsAdd, clsSub, clsFunct, clsImm} aluClass_t;
	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluSll, aluSrl, aluLui
	} aluOp_t;
	typedef enum logic {srcAPc, srcAReg} aluSrcA_t;
	typedef enum logic [2:0] {
		srcBReg, srcBFour, srcBSignImm, srcBBranchOff, srcBZeroImm
	} aluSrcB_t;
	typedef enum logic [1:0] {pcFromAlu, pcFromAluOut, pcFromJump, pcFromReg} pcSource_t;

	// access size, shared by loads and stores
	typedef enum logic [2:0] {sizeWord, sizeHalf, sizeHalfU, sizeByte, sizeByteU} memSize_t;

endpackage

// ==== hw/datapath/alu.sv ====
// 32-bit integer ALU
`timescale 1ns/10ps

module alu
	import mipsPkg::*;
(
	input  logic [WORD_W-1:0] a,
	input  logic [WORD_W-1:0] b,
	input  logic [4:0]        shamt,
	input  aluOp_t            aluOp,
	output logic [WORD_W-1:0] result,
	output logic              zero
);

	logic lessThan;

	assign lessThan = $signed(a) < $signed(b); // signed compare for slt and slti

	always_comb
	begin
		case (aluOp)
			aluAdd:  result = a + b;
			aluSub:  result = a - b;
			aluAnd:  result = a & b;
			aluOr:   result = a | b;
			aluSlt:  result = {{(WORD_W-1){1'b0}}, lessThan};
			aluSll:  result = b << shamt; // shifts act on rt
			aluSrl:  result = b >> shamt;
			aluLui:  result = {b[15:0], 16'b0};
			default: result = a + b;
		endcase
	end

	// beq and bne look at this after a subtract
	assign zero = (result == '0);

endmodule

// ==== hw/datapath/regFile.sv ====
// integer register file
`timescale 1ns/10ps

module regFile
	import mipsPkg::*;
(
	input  logic                  iCLK,
	input  logic                  iRST,
	input  logic [REG_ADDR_W-1:0] readAddr1,
	input  logic [REG_ADDR_W-1:0] readAddr2,
	input  logic [REG_ADDR_W-1:0] writeAddr,
	input  logic [WORD_W-1:0]     writeData,
	input  logic                  regWrite,
	output logic [WORD_W-1:0]     readData1,
	output logic [WORD_W-1:0]     readData2
);

	logic [WORD_W-1:0] regs [REG_COUNT];

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (regWrite && writeAddr != '0) // $zero stays zero
			regs[writeAddr] <= writeData;
	end

	assign readData1 = regs[readAddr1];
	assign readData2 = regs[readAddr2];

endmodule

// ==== hw/datapath/loadStoreAlign.sv ====
// load and store lane alignment
`timescale 1ns/10ps

module loadStoreAlign
	import mipsPkg::*;
(
	input  memSize_t          memSize,
	input  logic [1:0]        storeOffset,
	input  logic [1:0]        loadOffset,
	input  logic [WORD_W-1:0] storeData,
	input  logic [WORD_W-1:0] loadData,
	output logic [WORD_W-1:0] memWriteData,
	output logic [3:0]        byteEnable,
	output logic [WORD_W-1:0] loadResult
);

	logic [WORD_W-1:0] laneShifted;
	logic [7:0]        loadByte;
	logic [15:0]       loadHalf;

	// stores: copy the item into every lane, enables pick the one addressed
	always_comb
	begin
		case (memSize)
			sizeHalf, sizeHalfU:
			begin
				memWriteData = {2{storeData[15:0]}};
				byteEnable = storeOffset[1] ? 4'b1100 : 4'b0011;
			end
			sizeByte, sizeByteU:
			begin
				memWriteData = {4{storeData[7:0]}};
				byteEnable = 4'b0001 << storeOffset;
			end
			default:
			begin
				memWriteData = storeData;
				byteEnable = 4'b1111;
			end
		endcase
	end

	// loads: little-endian, lane 0 is bits 7:0
	assign laneShifted = loadData >> {loadOffset, 3'b000};
	assign loadByte = laneShifted[7:0];
	assign loadHalf = loadOffset[1] ? loadData[31:16] : loadData[15:0];

	always_comb
	begin
		case (memSize)
			sizeHalf:  loadResult = {{16{loadHalf[15]}}, loadHalf};
			sizeHalfU: loadResult = {16'b0, loadHalf};
			sizeByte:  loadResult = {{24{loadByte[7]}}, loadByte};
			sizeByteU: loadResult = {24'b0, loadByte};
			default:   loadResult = loadData;
		endcase
	end

endmodule

// ==== hw/control/aluDecoder.sv ====
// ALU operation decoder
`timescale 1ns/10ps

module aluDecoder
	import mipsPkg::*;
(
	input  aluClass_t aluClass,
	input  opcode_t   opcode,
	input  funct_t    funct,
	output aluOp_t    aluOp
);

	always_comb
	begin
		aluOp = aluAdd; // address and pc arithmetic
		case (aluClass)
			clsSub: aluOp = aluSub;
			clsFunct:
			begin
				case (funct)
					fnSub:   aluOp = aluSub;
					fnAnd:   aluOp = aluAnd;
					fnOr:    aluOp = aluOr;
					fnSlt:   aluOp = aluSlt;
					fnSll:   aluOp = aluSll;
					fnSrl:   aluOp = aluSrl;
					default: aluOp = aluAdd; // add and jr
				endcase
			end
			clsImm:
			begin
				case (opcode)
					opAndi:  aluOp = aluAnd;
					opOri:   aluOp = aluOr;
					opSlti:  aluOp = aluSlt;
					opLui:   aluOp = aluLui;
					default: aluOp = aluAdd;
				endcase
			end
			default: ;
		endcase
	end

endmodule

// ==== hw/control/controlFsm.sv ====
// multicycle control FSM
`timescale 1ns/10ps

module controlFsm
	import mipsPkg::*;
(
	input  logic       iCLK,
	input  logic       iRST,
	input  opcode_t    opcode,
	input  funct_t     funct,
	output ctrlState_t state,
	output logic       irWrite, pcWrite, branchEq, branchNe, iorD, memRead, memWrite,
	output logic       regWrite, regDst, memToReg, linkWrite,
	output aluSrcA_t   aluSrcA,
	output aluSrcB_t   aluSrcB,
	output pcSource_t  pcSource,
	output aluClass_t  aluClass,
	output memSize_t   memSize
);

	ctrlState_t nextState;
	logic       isStore;

	assign isStore = (opcode == opSw) || (opcode == opSh) || (opcode == opSb);

	always_ff @(posedge iCLK)
	begin
		if (iRST)
			state <= stFetch;
		else
			state <= nextState;
	end

	// sequencing
	always_comb
	begin
		nextState = stFetch; // most states end the instruction
		case (state)
			stFetch: nextState = stDecode;
			stDecode:
			begin
				case (opcode)
					opRType:
					begin
						case (funct)
							fnAdd, fnSub, fnAnd, fnOr, fnSlt, fnSll, fnSrl, fnJr:
								nextState = stRExec;
							default: nextState = stFetch; // unknown funct dropped
						endcase
					end
					opAddi, opAndi, opOri, opSlti, opLui: nextState = stIExec;
					opLw, opLh, opLhu, opLb, opLbu, opSw, opSh, opSb: nextState = stMemAddr;
					opBeq, opBne: nextState = stBranch;
					opJ:          nextState = stJump;
					opJal:        nextState = stJal;
					default:      nextState = stFetch;
				endcase
			end
			stMemAddr: nextState = isStore ? stMemWrite : stMemRead;
			stMemRead: nextState = stMemWriteBack;
			stRExec:   nextState = (funct == fnJr) ? stJumpReg : stRWriteBack;
			stIExec:   nextState = stIWriteBack;
			stJal:     nextState = stJump; // link first, then jump
			default:   nextState = stFetch;
		endcase
	end

	// per-state enables and selects
	always_comb
	begin
		irWrite = 1'b0;
		pcWrite = 1'b0;
		branchEq = 1'b0;
		branchNe = 1'b0;
		iorD = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		regWrite = 1'b0;
		regDst = 1'b0;
		memToReg = 1'b0;
		linkWrite = 1'b0;
		aluSrcA = srcAPc;
		aluSrcB = srcBFour;
		pcSource = pcFromAlu;
		aluClass = clsAdd;
		case (state)
			stFetch:
			begin
				memRead = 1'b1;
				irWrite = 1'b1;
				pcWrite = 1'b1; // pc + 4
			end
			stDecode: aluSrcB = srcBBranchOff; // branch target into ALUOut
			stMemAddr:
			begin
				aluSrcA = srcAReg;
				aluSrcB = srcBSignImm;
			end
			stMemRead:
			begin
				iorD = 1'b1;
				memRead = 1'b1;
			end
			stMemWriteBack:
			begin
				regWrite = 1'b1;
				memToReg = 1'b1;
			end
			stMemWrite:
			begin
				iorD = 1'b1;
				memWrite = 1'b1;
			end
			stRExec:
			begin
				aluSrcA = srcAReg;
				aluSrcB = srcBReg;
				aluClass = clsFunct;
			end
			stRWriteBack:
			begin
				regWrite = 1'b1;
				regDst = 1'b1; // rd
			end
			stIExec:
			begin
				aluSrcA = srcAReg;
				aluSrcB = (opcode == opAndi || opcode == opOri || opcode == opLui) ?
					srcBZeroImm : srcBSignImm;
				aluClass = clsImm;
			end
			stIWriteBack: regWrite = 1'b1;
			stBranch:
			begin
				aluSrcA = srcAReg;
				aluSrcB = srcBReg;
				aluClass = clsSub; // zero flag compares rs and rt
				pcSource = pcFromAluOut;
				branchEq = (opcode == opBeq);
				branchNe = (opcode == opBne);
			end
			stJump:
			begin
				pcWrite = 1'b1;
				pcSource = pcFromJump;
			end
			stJumpReg:
			begin
				pcWrite = 1'b1;
				pcSource = pcFromReg;
			end
			stJal:
			begin
				regWrite = 1'b1;
				linkWrite = 1'b1; // ra gets pc, already advanced
			end
			default: ;
		endcase
	end

	// access size from the load or store opcode
	always_comb
	begin
		case (opcode)
			opLh, opSh: memSize = sizeHalf;
			opLhu:      memSize = sizeHalfU;
			opLb, opSb: memSize = sizeByte;
			opLbu:      memSize = sizeByteU;
			default:    memSize = sizeWord;
		endcase
	end

endmodule

// ==== hw/datapath/multiDatapath.sv ====
// multicycle datapath
`timescale 1ns/10ps

module multiDatapath
	import mipsPkg::*;
#(
	parameter logic [WORD_W-1:0] RESET_PC = '0
)(
	input  logic              iCLK,
	input  logic              iRST,
	input  logic              irWrite, pcWrite, branchEq, branchNe, iorD, memRead, memWrite,
	input  logic              regWrite, regDst, memToReg, linkWrite,
	input  aluSrcA_t          aluSrcA,
	input  aluSrcB_t          aluSrcB,
	input  pcSource_t         pcSource,
	input  aluClass_t         aluClass,
	input  memSize_t          memSize,
	output opcode_t           opcode,
	output funct_t            funct,
	output logic [WORD_W-1:0] pc,
	output logic [WORD_W-1:0] memAddress,
	output logic [WORD_W-1:0] memWriteData,
	input  logic [WORD_W-1:0] memReadData,
	output logic [3:0]        memByteEnable,
	output logic              memReadEnable,
	output logic              memWriteEnable
);

	logic [WORD_W-1:0] ir, aReg, bReg, mdr, aluOut;
	logic [1:0]        addrLow; // offset of the last data access
	logic [WORD_W-1:0] readData1, readData2, aluA, aluB, aluResult, pcNext;
	logic [WORD_W-1:0] signImm, zeroImm, branchOff, jumpTarget, loadResult, writeData;
	logic [REG_ADDR_W-1:0] writeAddr;
	logic              aluZero, pcEn;
	aluOp_t            aluOp;

	// instruction fields
	assign opcode     = opcode_t'(ir[31:26]);
	assign funct      = funct_t'(ir[5:0]);
	assign signImm    = {{16{ir[15]}}, ir[15:0]};
	assign zeroImm    = {16'b0, ir[15:0]};
	assign branchOff  = {{14{ir[15]}}, ir[15:0], 2'b00};
	assign jumpTarget = {pc[31:28], ir[25:0], 2'b00}; // pc is already +4

	assign aluA = (aluSrcA == srcAReg) ? aReg : pc;
	always_comb
	begin
		case (aluSrcB)
			srcBReg:       aluB = bReg;
			srcBFour:      aluB = 32'd4;
			srcBSignImm:   aluB = signImm;
			srcBBranchOff: aluB = branchOff;
			srcBZeroImm:   aluB = zeroImm;
			default:       aluB = '0;
		endcase
	end

	always_comb
	begin
		case (pcSource)
			pcFromAlu:    pcNext = aluResult;
			pcFromAluOut: pcNext = aluOut; // branch target from decode
			pcFromJump:   pcNext = jumpTarget;
			default:      pcNext = aReg; // jr
		endcase
	end

	assign pcEn = pcWrite || (branchEq && aluZero) || (branchNe && !aluZero);

	// write-back target and source, jal overrides both
	assign writeAddr = linkWrite ? RA_REG : (regDst ? ir[15:11] : ir[20:16]);
	assign writeData = linkWrite ? pc : (memToReg ? loadResult : aluOut);

	assign memAddress     = iorD ? aluOut : pc;
	assign memReadEnable  = memRead;
	assign memWriteEnable = memWrite;

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			pc <= RESET_PC;
			ir <= '0;
			aReg <= '0;
			bReg <= '0;
			mdr <= '0;
			aluOut <= '0;
			addrLow <= '0;
		end
		else
		begin
			aReg <= readData1;
			bReg <= readData2;
			mdr <= memReadData;
			aluOut <= aluResult;
			if (irWrite)
				ir <= memReadData;
			if (pcEn)
				pc <= pcNext;
			if (iorD)
				addrLow <= memAddress[1:0]; // kept for load write-back
		end
	end

	regFile rf0 (
		.iCLK(iCLK), .iRST(iRST),
		.readAddr1(ir[25:21]), .readAddr2(ir[20:16]), .writeAddr(writeAddr),
		.writeData(writeData), .regWrite(regWrite),
		.readData1(readData1), .readData2(readData2)
	);

	aluDecoder dec0 (.aluClass(aluClass), .opcode(opcode), .funct(funct), .aluOp(aluOp));

	alu alu0 (
		.a(aluA), .b(aluB), .shamt(ir[10:6]), .aluOp(aluOp),
		.result(aluResult), .zero(aluZero)
	);

	loadStoreAlign lsa0 (
		.memSize(memSize), .storeOffset(memAddress[1:0]), .loadOffset(addrLow),
		.storeData(bReg), .loadData(mdr),
		.memWriteData(memWriteData), .byteEnable(memByteEnable), .loadResult(loadResult)
	);

endmodule

// ==== hw/mipsCore.sv ====
// multicycle MIPS core top
`timescale 1ns/10ps

module mipsCore
	import mipsPkg::*;
#(
	parameter logic [WORD_W-1:0] RESET_PC = '0
)(
	input  logic              iCLK,
	input  logic              iRST,
	output logic [WORD_W-1:0] memAddress,
	output logic [WORD_W-1:0] memWriteData,
	input  logic [WORD_W-1:0] memReadData,
	output logic [3:0]        memByteEnable,
	output logic              memReadEnable,
	output logic              memWriteEnable,
	output logic [WORD_W-1:0] pc,
	output ctrlState_t        state
);

	opcode_t   opcode;
	funct_t    funct;
	logic      irWrite, pcWrite, branchEq, branchNe, iorD;
	logic      memRead, memWrite, regWrite, regDst, memToReg, linkWrite;
	aluSrcA_t  aluSrcA;
	aluSrcB_t  aluSrcB;
	pcSource_t pcSource;
	aluClass_t aluClass;
	memSize_t  memSize;

	controlFsm ctrl0 (
		.iCLK(iCLK), .iRST(iRST),
		.opcode(opcode), .funct(funct), .state(state),
		.irWrite(irWrite), .pcWrite(pcWrite), .branchEq(branchEq), .branchNe(branchNe),
		.iorD(iorD), .memRead(memRead), .memWrite(memWrite), .regWrite(regWrite),
		.regDst(regDst), .memToReg(memToReg), .linkWrite(linkWrite),
		.aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .pcSource(pcSource),
		.aluClass(aluClass), .memSize(memSize)
	);

	multiDatapath #(.RESET_PC(RESET_PC)) dp0 (
		.iCLK(iCLK), .iRST(iRST),
		.irWrite(irWrite), .pcWrite(pcWrite), .branchEq(branchEq), .branchNe(branchNe),
		.iorD(iorD), .memRead(memRead), .memWrite(memWrite), .regWrite(regWrite),
		.regDst(regDst), .memToReg(memToReg), .linkWrite(linkWrite),
		.aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .pcSource(pcSource),
		.aluClass(aluClass), .memSize(memSize),
		.opcode(opcode), .funct(funct), .pc(pc),
		.memAddress(memAddress), .memWriteData(memWriteData), .memReadData(memReadData),
		.memByteEnable(memByteEnable), .memReadEnable(memReadEnable),
		.memWriteEnable(memWriteEnable)
	);

endmodule

// ==== verif/coreTests.svh ====
// directed core tests
`ifndef CORE_TESTS_SVH
`define CORE_TESTS_SVH

localparam int N_RESET = 1;
localparam int N_ARITH = 25;
localparam int N_STORE = 9;
localparam int N_LOAD  = 27;
localparam int N_CTRL  = 21;
localparam int N_CYC   = 7;
localparam int WATCHDOG_CYCLES = (N_RESET + N_ARITH + N_STORE + N_LOAD + N_CTRL + N_CYC) * 5
	+ 6 * 100;

function automatic logic [31:0] rInstr(funct_t fn, int rs, int rt, int rd, int sh);
	return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
endfunction

function automatic logic [31:0] iInstr(opcode_t op, int rs, int rt, logic [15:0] imm);
	return {op, rs[4:0], rt[4:0], imm};
endfunction

function automatic logic [31:0] jInstr(opcode_t op, logic [31:0] target);
	return {op, target[27:2]};
endfunction

// memory write through the model in one cycle
task automatic putWord(logic [31:0] addr, logic [31:0] data);
	loadEn = 1'b1;
	loadAddr = addr;
	loadData = data;
	@(posedge iCLK);
	#5;
	loadEn = 1'b0;
endtask

task automatic emit(logic [31:0] w);
	putWord(32'(progPtr), w);
	progPtr += 4;
endtask

task automatic emitEnd(output logic [31:0] endAddr);
	endAddr = 32'(progPtr);
	emit(jInstr(opJ, endAddr)); // jump to itself
endtask

task automatic expectWord(logic [31:0] addr, logic [31:0] data);
	expAddrQ.push_back(addr);
	expDataQ.push_back(data);
endtask

task automatic startTest();
	iRST = 1'b1;
	fillReq = 1'b1;
	@(posedge iCLK);
	#5;
	fillReq = 1'b0;
	progPtr = 0;
	expAddrQ.delete();
	expDataQ.delete();
endtask

task automatic releaseReset();
	repeat (15) @(posedge iCLK);
	#5;
	iRST = 1'b0;
endtask

// done when the self jump is fetched twice
task automatic runProgram(logic [31:0] endAddr, string name);
	int          fetches;
	logic [31:0] addr;
	fetches = 0;
	releaseReset();
	while (fetches < 2)
	begin
		@(negedge iCLK);
		if (state == stFetch && pc == endAddr)
			fetches++;
	end
	@(posedge iCLK);
	#5;
	while (expAddrQ.size() > 0)
	begin
		addr = expAddrQ.pop_front();
		checkWord(mem[addr[11:2]], expDataQ.pop_front(),
			$sformatf("%s word %h", name, addr));
	end
endtask

task automatic testReset();
	repeat (15) @(negedge iCLK);
	checkState(state, stFetch, "state in reset");
	checkWord(pc, 32'h0, "pc in reset");
	checkBit(memWriteEnable, 1'b0, "write enable in reset");
	@(posedge iCLK);
	#5;
	iRST = 1'b0;
	@(negedge iCLK);
	checkBit(memReadEnable, 1'b1, "first fetch read");
	checkWord(memAddress, 32'h0, "first fetch address");
	@(posedge iCLK);
	#5;
endtask

task automatic testArith();
	logic [31:0] a, b, endAddr, immS;
	logic [15:0] imm;
	logic [31:0] res [10];
	int          sh;
	startTest();
	a = randBits(32);
	b = randBits(32);
	imm = 16'(randBits(16));
	sh = randBits(5);
	immS = {{16{imm[15]}}, imm};
	emit(iInstr(opLui, 0, 1, a[31:16]));
	emit(iInstr(opOri, 1, 1, a[15:0]));
	emit(iInstr(opLui, 0, 2, b[31:16]));
	emit(iInstr(opOri, 2, 2, b[15:0]));
	emit(rInstr(fnAdd, 1, 2, 3, 0));
	res[0] = a + b;
	emit(iInstr(opSw, 0, 3, 16'h0800));
	emit(rInstr(fnSub, 1, 2, 3, 0));
	res[1] = a - b;
	emit(iInstr(opSw, 0, 3, 16'h0804));
	emit(rInstr(fnAnd, 1, 2, 3, 0));
	res[2] = a & b;
	emit(iInstr(opSw, 0, 3, 16'h0808));
	emit(rInstr(fnOr, 1, 2, 3, 0));
	res[3] = a | b;
	emit(iInstr(opSw, 0, 3, 16'h080c));
	emit(rInstr(fnSlt, 1, 2, 3, 0));
	res[4] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
	emit(iInstr(opSw, 0, 3, 16'h0810));
	emit(rInstr(fnSll, 0, 2, 3, sh));
	res[5] = b << sh;
	emit(iInstr(opSw, 0, 3, 16'h0814));
	emit(rInstr(fnSrl, 0, 2, 3, sh));
	res[6] = b >> sh;
	emit(iInstr(opSw, 0, 3, 16'h0818));
	emit(iInstr(opAddi, 1, 3, imm));
	res[7] = a + immS;
	emit(iInstr(opSw, 0, 3, 16'h081c));
	emit(iInstr(opAndi, 1, 3, imm));
	res[8] = a & {16'h0, imm}; // zero-extended
	emit(iInstr(opSw, 0, 3, 16'h0820));
	emit(iInstr(opSlti, 1, 3, imm));
	res[9] = ($signed(a) < $signed(immS)) ? 32'd1 : 32'd0;
	emit(iInstr(opSw, 0, 3, 16'h0824));
	emitEnd(endAddr);
	for (int k = 0; k < 10; k++)
		expectWord(32'h800 + 32'(4 * k), res[k]);
	runProgram(endAddr, "arith");
endtask

task automatic testStores();
	logic [31:0] v, endAddr;
	logic [31:0] old [6];
	startTest();
	v = randBits(32);
	for (int k = 0; k < 6; k++)
	begin
		old[k] = randBits(32);
		putWord(32'h900 + 32'(4 * k), old[k]);
	end
	emit(iInstr(opLui, 0, 1, v[31:16]));
	emit(iInstr(opOri, 1, 1, v[15:0]));
	for (int k = 0; k < 4; k++)
	begin
		emit(iInstr(opSb, 0, 1, 16'h0900 + 16'(5 * k))); // byte k of word k
		expectWord(32'h900 + 32'(4 * k),
			(old[k] & ~(32'hff << (8 * k))) | (32'(v[7:0]) << (8 * k)));
	end
	emit(iInstr(opSh, 0, 1, 16'h0910));
	expectWord(32'h910, {old[4][31:16], v[15:0]});
	emit(iInstr(opSh, 0, 1, 16'h0916));
	expectWord(32'h914, {v[15:0], old[5][15:0]});
	emitEnd(endAddr);
	runProgram(endAddr, "stores");
endtask

function automatic logic [31:0] loadExpect(opcode_t op, logic [31:0] w, int off);
	logic [31:0] s;
	s = w >> (8 * off);
	case (op)
		opLb:    return {{24{s[7]}}, s[7:0]};
		opLbu:   return {24'h0, s[7:0]};
		opLh:    return {{16{s[15]}}, s[15:0]};
		opLhu:   return {16'h0, s[15:0]};
		default: return w;
	endcase
endfunction

task automatic loadPair(opcode_t op, logic [31:0] w, int off, inout int slot);
	emit(iInstr(op, 0, 3, 16'h0a00 + 16'(off)));
	emit(iInstr(opSw, 0, 3, 16'h0a10 + 16'(4 * slot)));
	expectWord(32'ha10 + 32'(4 * slot), loadExpect(op, w, off));
	slot++;
endtask

task automatic testLoads();
	logic [31:0] w, endAddr;
	int          slot;
	startTest();
	slot = 0;
	w = randBits(32);
	w[7] = 1'b1; // at least one negative byte and half
	w[31] = 1'b1;
	putWord(32'ha00, w);
	for (int k = 0; k < 4; k++)
		loadPair(opLb, w, k, slot);
	for (int k = 0; k < 4; k++)
		loadPair(opLbu, w, k, slot);
	for (int k = 0; k < 4; k += 2)
	begin
		loadPair(opLh, w, k, slot);
		loadPair(opLhu, w, k, slot);
	end
	loadPair(opLw, w, 0, slot);
	emitEnd(endAddr);
	runProgram(endAddr, "loads");
endtask

task automatic testControlFlow();
	logic [31:0] endAddr;
	startTest();
	emit(iInstr(opAddi, 0, 1, 16'd5));
	emit(iInstr(opAddi, 0, 2, 16'd5));
	emit(iInstr(opAddi, 0, 3, 16'd7));
	emit(iInstr(opOri, 0, 4, 16'h1234)); // marker
	emit(iInstr(opBeq, 1, 2, 16'd1));    // taken
	emit(iInstr(opSw, 0, 4, 16'h0b00));
	emit(iInstr(opBeq, 1, 3, 16'd1));    // falls through
	emit(iInstr(opSw, 0, 4, 16'h0b04));
	emit(iInstr(opBne, 1, 3, 16'd1));    // taken
	emit(iInstr(opSw, 0, 4, 16'h0b08));
	emit(iInstr(opBne, 1, 2, 16'd1));    // falls through
	emit(iInstr(opSw, 0, 4, 16'h0b0c));
	emit(jInstr(opJ, 32'h38));
	emit(iInstr(opSw, 0, 4, 16'h0b10));
	emit(jInstr(opJal, 32'h44));         // at 0x38
	emit(iInstr(opSw, 0, 4, 16'h0b14)); // return lands here
	emit(jInstr(opJ, 32'h50));
	emit(iInstr(opSw, 0, 31, 16'h0b18)); // subroutine
	emit(rInstr(fnJr, 31, 0, 0, 0));
	emit(iInstr(opSw, 0, 4, 16'h0b1c));
	emitEnd(endAddr);
	expectWord(32'hb00, fillWord(32'hb00 >> 2));
	expectWord(32'hb04, 32'h1234);
	expectWord(32'hb08, fillWord(32'hb08 >> 2));
	expectWord(32'hb0c, 32'h1234);
	expectWord(32'hb10, fillWord(32'hb10 >> 2));
	expectWord(32'hb14, 32'h1234);
	expectWord(32'hb18, 32'h3c); // jal address plus 4
	expectWord(32'hb1c, fillWord(32'hb1c >> 2));
	runProgram(endAddr, "control");
endtask

task automatic testCycleCount();
	logic [31:0] endAddr;
	int          cycles;
	logic        found;
	startTest();
	emit(rInstr(fnAdd, 1, 2, 3, 0));    // 4
	emit(iInstr(opBeq, 0, 0, 16'd0));   // 3
	emit(iInstr(opLw, 0, 5, 16'h0800)); // 5
	emit(iInstr(opSw, 0, 5, 16'h0804)); // 4
	emit(iInstr(opAddi, 0, 6, 16'd9));  // 4
	emit(32'hfc00_0000);                // unknown opcode takes 2
	emitEnd(endAddr);
	releaseReset();
	cycles = -1;
	found = 1'b0;
	while (!found)
	begin
		@(negedge iCLK);
		cycles++;
		if (state == stFetch && pc == endAddr)
			found = 1'b1;
	end
	checkWord(32'(cycles), 32'd22, "cycles to final fetch");
	@(posedge iCLK);
	#5;
endtask

`endif

// ==== verif/coreTb.sv ====
// MIPS core testbench
`timescale 1ns/10ps

module coreTb
	import mipsPkg::*;
;

	localparam int MEM_WORDS = 1024;

	logic              iCLK;
	logic              iRST;
	logic [WORD_W-1:0] memAddress, memWriteData, memReadData, pc;
	logic [3:0]        memByteEnable;
	logic              memReadEnable, memWriteEnable;
	ctrlState_t        state;

	// behavioral memory that the tests also load through loadEn
	logic [WORD_W-1:0] mem [MEM_WORDS];
	logic              fillReq, loadEn;
	logic [WORD_W-1:0] loadAddr, loadData;
	logic [31:0]       lfsrState;
	int                progPtr; // next program address
	logic [WORD_W-1:0] expAddrQ[$];
	logic [WORD_W-1:0] expDataQ[$];

	mipsCore #(.RESET_PC(32'h0)) dut0 (
		.iCLK(iCLK), .iRST(iRST),
		.memAddress(memAddress), .memWriteData(memWriteData), .memReadData(memReadData),
		.memByteEnable(memByteEnable), .memReadEnable(memReadEnable),
		.memWriteEnable(memWriteEnable), .pc(pc), .state(state)
	);

	initial
	begin
		iCLK = 1'b0;
		forever #50 iCLK = ~iCLK; // 100 ns period
	end

	// fill pattern where the odd multiplier keeps every word distinct
	function automatic logic [WORD_W-1:0] fillWord(int idx);
		return (32'(idx) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
	endfunction

	always @(posedge iCLK)
	begin
		if (fillReq)
		begin
			for (int i = 0; i < MEM_WORDS; i++)
				mem[i] <= fillWord(i);
		end
		else if (loadEn)
			mem[loadAddr[11:2]] <= loadData;
		else if (memWriteEnable)
		begin
			for (int b = 0; b < 4; b++)
				if (memByteEnable[b])
					mem[memAddress[11:2]][8*b +: 8] <= memWriteData[8*b +: 8];
		end
	end

	assign memReadData = mem[memAddress[11:2]]; // zero-cycle read

	// fibonacci LFSR with taps 32 22 2 1 and one step per bit
	function automatic logic [31:0] randBits(int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic reportFail(string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkWord(logic [WORD_W-1:0] got, logic [WORD_W-1:0] exp, string msg);
		if (got !== exp)
			reportFail($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp));
	endtask

	task automatic checkState(ctrlState_t got, ctrlState_t exp, string msg);
		if (got !== exp)
			reportFail($sformatf("MISMATCH at %0t: %s got %s expected %s",
				$time, msg, got.name(), exp.name()));
	endtask

	task automatic checkBit(logic got, logic exp, string msg);
		if (got !== exp)
			reportFail($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, msg, got, exp));
	endtask

	`include "coreTests.svh"

	// budget per test is instructions x 5 plus 100 cycles
	initial
	begin
		#(WATCHDOG_CYCLES * 100);
		reportFail("timeout: the core never reached the end of a test program");
	end

	initial
	begin
		iRST = 1'b1;
		fillReq = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		lfsrState = 32'hdd41_0dd7;
		progPtr = 0;
		testReset();
		testArith();
		testStores();
		testLoads();
		testControlFlow();
		testCycleCount();
		$display("All checks passed");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+verif
common/mipsPkg.sv
hw/datapath/alu.sv
hw/datapath/regFile.sv
hw/datapath/loadStoreAlign.sv
hw/control/aluDecoder.sv
hw/control/controlFsm.sv
hw/datapath/multiDatapath.sv
hw/mipsCore.sv
verif/coreTb.sv

// ==== runSim.sh ====
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module coreTb -f flist.f -o coreSim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/coreSim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Checks failed" sim.log; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
exit 0
